/* tb.f */
+incdir+source
source/rv_ex_pkg.sv
source/imm_gen.sv
source/ex_ctrl.sv
source/alu.sv
source/branch_unit.sv
source/ex_mem_reg.sv
source/ex_stage.sv
verif/ex_stage_tb.sv

/* verif/ex_stage_tb.sv */
`include "rv_ex_consts.svh"

module ex_stage_tb import rv_ex_pkg::*; ();

    // Instructions per directed test set the watchdog limit
    localparam int RESET_CYCLES    = 5;
    localparam int R_COUNT         = 40;
    localparam int I_COUNT         = 24;
    localparam int BR_COUNT        = 30;
    localparam int JMP_COUNT       = 8;
    localparam int CSR_COUNT       = 12;
    localparam int BP_COUNT        = 60;
    localparam int TOTAL_INSTS     = R_COUNT + I_COUNT + BR_COUNT + JMP_COUNT + CSR_COUNT
                                     + BP_COUNT;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTS * 20 + RESET_CYCLES;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    ex_in_t  in_data;
    logic    out_valid;
    logic    out_ready;
    ex_out_t out_data;

    ex_in_t      send_q[$];
    ex_out_t     exp_q[$];
    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    logic        random_ready;

    // Handshake state seen in the previous cycle
    logic        prev_accept;
    logic        prev_valid;
    logic        prev_ready;
    ex_out_t     prev_data;

    ex_stage u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Instruction encoders built through the format views
    function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        inst_word_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = `RV_OP_REG;
        return w;
    endfunction

    function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        inst_word_u w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] s_word(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        inst_word_u w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = 3'b010;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = `RV_OP_STORE;
        return w;
    endfunction

    // B offset scattered over the S fields
    function automatic logic [31:0] b_word(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        inst_word_u w;
        w.s.imm_hi = {imm[12], imm[10:5]};
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = f3;
        w.s.imm_lo = {imm[4:1], imm[11]};
        w.s.opcode = `RV_OP_BRANCH;
        return w;
    endfunction

    function automatic logic [31:0] u_word(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        inst_word_u w;
        w.u.imm    = imm;
        w.u.rd     = rd;
        w.u.opcode = op;
        return w;
    endfunction

    function automatic logic [31:0] j_word(logic [20:0] imm, logic [4:0] rd);
        inst_word_u w;
        w.u.imm    = {imm[20], imm[10:1], imm[11], imm[19:12]};
        w.u.rd     = rd;
        w.u.opcode = `RV_OP_JAL;
        return w;
    endfunction

    // RV32I integer semantics where alt selects SUB or SRA
    function automatic logic [31:0] reference_arith(logic [2:0] f3, logic alt,
                                                    logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Expected stage output from the raw instruction bits
    function automatic ex_out_t expected_result(ex_in_t x);
        logic [31:0] w;
        logic [6:0]  op;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] src;
        logic [31:0] res;
        logic        taken;
        ex_out_t     o;
        w     = x.inst;
        op    = w[6:0];
        f3    = w[14:12];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        src   = f3[2] ? {27'b0, w[19:15]} : x.rs1_data;
        taken = 1'b0;
        res   = '0;
        case (op)
            `RV_OP_REG:    res = reference_arith(f3, w[30], x.rs1_data, x.rs2_data);
            `RV_OP_IMM:    res = reference_arith(f3, w[30] && f3 == 3'd5, x.rs1_data, imm_i);
            `RV_OP_LUI:    res = imm_u;
            `RV_OP_AUIPC:  res = x.pc + imm_u;
            `RV_OP_LOAD:   res = x.rs1_data + imm_i;
            `RV_OP_STORE:  res = x.rs1_data + imm_s;
            `RV_OP_BRANCH: begin
                res   = x.pc + imm_b;
                taken = branch_taken(f3, x.rs1_data, x.rs2_data);
            end
            `RV_OP_JAL: begin
                res   = x.pc + imm_j;
                taken = 1'b1;
            end
            `RV_OP_JALR: begin
                res   = (x.rs1_data + imm_i) & ~32'd1;
                taken = 1'b1;
            end
            default: begin
                // SYSTEM gives the trap return target or the new CSR value
                if (f3 == 3'd0) begin
                    res   = x.csr_rdata;
                    taken = 1'b1;
                end else if (f3[1:0] == 2'b01) begin
                    res = src;
                end else if (f3[1:0] == 2'b10) begin
                    res = x.csr_rdata | src;
                end else begin
                    res = x.csr_rdata & ~src;
                end
            end
        endcase
        o.rd          = w[11:7];
        o.alu_result  = res;
        o.csr_wdata   = res;
        o.redirect    = taken;
        o.redirect_pc = res;
        if (op == `RV_OP_JAL || op == `RV_OP_JALR) begin
            o.rd_wdata = x.pc + 32'd4;
        end else if (op == `RV_OP_SYSTEM && f3 != 3'd0) begin
            o.rd_wdata = x.csr_rdata;
        end else begin
            o.rd_wdata = res;
        end
        return o;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic compare_result(ex_out_t got, ex_out_t exp);
        check_value("rd", {27'b0, got.rd}, {27'b0, exp.rd});
        check_value("rd_wdata", got.rd_wdata, exp.rd_wdata);
        check_value("alu_result", got.alu_result, exp.alu_result);
        check_value("csr_wdata", got.csr_wdata, exp.csr_wdata);
        check_value("redirect", {31'b0, got.redirect}, {31'b0, exp.redirect});
        check_value("redirect_pc", got.redirect_pc, exp.redirect_pc);
    endtask

    // Random pc and CSR value around the given instruction and operands
    task automatic push_inst(logic [31:0] word, logic [31:0] rs1d, logic [31:0] rs2d);
        ex_in_t x;
        x.inst      = word;
        x.pc        = next_rand() & ~32'd3;
        x.rs1_data  = rs1d;
        x.rs2_data  = rs2d;
        x.csr_rdata = next_rand();
        send_q.push_back(x);
    endtask

    // Drive at the falling edge and check the settled handshake
    task automatic cycle();
        logic [31:0] r;
        logic        accepted;
        logic        exp_valid;
        ex_out_t     exp_out;
        @(negedge clk);
        r         = next_rand();
        out_ready = random_ready ? (r[31:30] != 2'b00) : 1'b1;
        if (send_q.size() > 0) begin
            in_valid = 1'b1;
            in_data  = send_q[0];
        end else begin
            in_valid = 1'b0;
            in_data  = '0;
        end
        #1;
        exp_valid = prev_accept || (prev_valid && !prev_ready);
        check_value("out_valid", {31'b0, out_valid}, {31'b0, exp_valid});
        check_value("in_ready", {31'b0, in_ready}, {31'b0, !exp_valid || out_ready});
        if (prev_valid && !prev_ready) begin
            checks++;
            assert (out_data === prev_data) else begin
                errors++;
                $display("Mismatch out_data under stall: got %h, expected %h",
                         out_data, prev_data);
            end
        end
        if (out_valid && out_ready) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("A result left the stage with no instruction in flight");
            end
            if (exp_q.size() > 0) begin
                exp_out = exp_q.pop_front();
                compare_result(out_data, exp_out);
            end
        end
        accepted = in_valid && in_ready;
        if (accepted) begin
            exp_q.push_back(expected_result(send_q.pop_front()));
        end
        prev_accept = accepted;
        prev_valid  = exp_valid;
        prev_ready  = out_ready;
        prev_data   = out_data;
    endtask

    task automatic drain();
        while (send_q.size() > 0 || exp_q.size() > 0) begin
            cycle();
        end
        cycle();
    endtask

    // Ten ops with SUB and SRA through funct7 bit 5
    task automatic r_type_ops();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            f7 = (k < 8) ? 7'h00 : 7'h20;
            for (int n = 0; n < R_COUNT / 10; n++) begin
                a = next_rand();
                b = next_rand();
                push_inst(r_word(f7, 5'd2, 5'd1, f3, 5'(k + 1)), a, b);
            end
        end
        drain();
    endtask

    task automatic i_type_ops();
        logic [31:0] r;
        logic [31:0] a;
        logic [11:0] imm;
        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 2; n++) begin
                r = next_rand();
                a = next_rand();
                if (k == 1) begin
                    imm = {7'h00, r[4:0]};
                end else if (k == 5) begin
                    imm = {(n == 0) ? 7'h00 : 7'h20, r[4:0]};
                end else begin
                    imm = r[11:0];
                end
                push_inst(i_word(imm, 5'd3, 3'(k), 5'd4, `RV_OP_IMM), a, 32'd0);
            end
        end
        for (int n = 0; n < 2; n++) begin
            r = next_rand();
            a = next_rand();
            push_inst(u_word(r[31:12], 5'd5, `RV_OP_LUI), a, 32'd0);
            push_inst(u_word(r[19:0], 5'd6, `RV_OP_AUIPC), a, 32'd0);
            push_inst(i_word(r[11:0], 5'd7, 3'b010, 5'd8, `RV_OP_LOAD), a, 32'd0);
            push_inst(s_word(r[23:12], 5'd9, 5'd7), a, r);
        end
        drain();
    endtask

    // Equal, less and greater pairs where the last two differ signed and unsigned
    task automatic branch_conditions();
        logic [31:0] lhs [0:4];
        logic [31:0] rhs [0:4];
        logic [31:0] r;
        logic [2:0]  f3;
        lhs = '{32'd5, 32'd3, 32'd9, 32'hffff_fff0, 32'd7};
        rhs = '{32'd5, 32'd9, 32'd3, 32'd7, 32'hffff_fff0};
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int p = 0; p < 5; p++) begin
                r = next_rand();
                push_inst(b_word({r[12:1], 1'b0}, 5'd2, 5'd1, f3), lhs[p], rhs[p]);
            end
        end
        drain();
    endtask

    task automatic jumps_and_traps();
        logic [31:0] r;
        logic [31:0] a;
        for (int n = 0; n < JMP_COUNT / 4; n++) begin
            r = next_rand();
            a = next_rand();
            push_inst(j_word({r[20:1], 1'b0}, 5'd1), a, 32'd0);
            push_inst(i_word(r[11:0], 5'd5, 3'b000, 5'd1, `RV_OP_JALR), a, 32'd0);
            push_inst(32'h0000_0073, a, 32'd0);
            push_inst(32'h3020_0073, a, 32'd0);
        end
        drain();
    endtask

    // CSRRW, CSRRS, CSRRC and the immediate forms
    task automatic csr_ops();
        logic [31:0] r;
        logic [31:0] a;
        logic [2:0]  f3;
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 3) ? 3'(k + 1) : 3'(k + 2);
            for (int n = 0; n < CSR_COUNT / 6; n++) begin
                r = next_rand();
                a = next_rand();
                push_inst(i_word(12'h300, r[4:0], f3, 5'd6, `RV_OP_SYSTEM), a, 32'd0);
            end
        end
        drain();
    endtask

    task automatic back_pressure();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        random_ready = 1'b1;
        for (int n = 0; n < BP_COUNT; n++) begin
            r = next_rand();
            a = next_rand();
            b = next_rand();
            if (r[31:30] < 2'd2) begin
                push_inst(r_word({1'b0, r[15], 5'b0}, 5'd2, 5'd1, r[14:12], r[20:16]), a, b);
            end else if (r[31:30] == 2'd2) begin
                push_inst(i_word(r[11:0], 5'd1, 3'b010, r[20:16], `RV_OP_LOAD), a, b);
            end else begin
                f3 = r[20] ? {1'b1, r[22:21]} : {2'b00, r[21]};
                push_inst(b_word({r[12:1], 1'b0}, 5'd2, 5'd1, f3), a, r[23] ? a : b);
            end
        end
        drain();
        random_ready = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        out_ready    = 1'b0;
        errors       = 0;
        checks       = 0;
        lcg_state    = 32'hcab5_2375;
        random_ready = 1'b0;
        prev_accept  = 1'b0;
        prev_valid   = 1'b0;
        prev_ready   = 1'b0;
        prev_data    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("out_valid after reset", {31'b0, out_valid}, 32'd0);
        r_type_ops();
        i_type_ops();
        branch_conditions();
        jumps_and_traps();
        csr_ops();
        back_pressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* source/ex_stage.sv */
`include "rv_ex_consts.svh"

module ex_stage import rv_ex_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    output logic    in_ready,
    input  ex_in_t  in_data,
    output logic    out_valid,
    input  logic    out_ready,
    output ex_out_t out_data
);

    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] in1;
    logic [`RV_XLEN-1:0] in2;
    logic [`RV_XLEN-1:0] alu_result;
    logic [2:0]          branch_alu_op;
    logic [3:0]          alu_op;
    wb_sel_e             wb_sel;
    logic                taken;

    imm_gen u_imm_gen (
        .inst (in_data.inst),
        .imm  (imm)
    );

    ex_ctrl u_ex_ctrl (
        .clk           (clk),
        .in_valid      (in_valid),
        .opcode        (in_data.inst.r.opcode),
        .funct3        (in_data.inst.r.funct3),
        .funct7        (in_data.inst.r.funct7),
        .data1         (in_data.rs1_data),
        .data2         (in_data.rs2_data),
        .pc            (in_data.pc),
        .imm           (imm),
        .z_            (in_data.csr_rdata),
        .in1           (in1),
        .in2           (in2),
        .branch_alu_op (branch_alu_op),
        .alu_op        (alu_op),
        .wb_sel        (wb_sel)
    );

    alu u_alu (
        .alu_op (alu_op),
        .in1    (in1),
        .in2    (in2),
        .result (alu_result)
    );

    // Compares the raw register operands, not the ALU inputs
    branch_unit u_branch_unit (
        .branch_alu_op (branch_alu_op),
        .data1         (in_data.rs1_data),
        .data2         (in_data.rs2_data),
        .taken         (taken)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .pc         (in_data.pc),
        .rd         (in_data.inst.r.rd),
        .wb_sel     (wb_sel),
        .alu_result (alu_result),
        .csr_rdata  (in_data.csr_rdata),
        .taken      (taken),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

endmodule

/* source/ex_mem_reg.sv */
`include "rv_ex_consts.svh"

module ex_mem_reg import rv_ex_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [4:0]          rd,
    input  wb_sel_e             wb_sel,
    input  logic [`RV_XLEN-1:0] alu_result,
    input  logic [`RV_XLEN-1:0] csr_rdata,
    input  logic                taken,
    output logic                out_valid,
    input  logic                out_ready,
    output ex_out_t             out_data
);

    logic [`RV_XLEN-1:0] rd_wdata;
    ex_out_t             next_out;
    logic                accept;

    // Register is free when empty or being drained this cycle
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_comb begin
        case (wb_sel)
            WB_LINK: rd_wdata = pc + `RV_XLEN'd4;
            WB_CSR:  rd_wdata = csr_rdata;
            default: rd_wdata = alu_result;
        endcase
    end

    // New CSR value and jump target both come out of the ALU
    always_comb begin
        next_out.rd          = rd;
        next_out.rd_wdata    = rd_wdata;
        next_out.alu_result  = alu_result;
        next_out.csr_wdata   = alu_result;
        next_out.redirect    = taken;
        next_out.redirect_pc = alu_result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= next_out;
        end
    end

    // A stalled result must not change before the memory stage takes it
    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* source/branch_unit.sv */
`include "rv_ex_consts.svh"

module branch_unit (
    input  logic [2:0]          branch_alu_op,
    input  logic [`RV_XLEN-1:0] data1,
    input  logic [`RV_XLEN-1:0] data2,
    output logic                taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (data1 == data2);
    assign lt_s = ($signed(data1) < $signed(data2));
    assign lt_u = (data1 < data2);

    always_comb begin
        case (branch_alu_op)
            `BR_BEQ: begin
                taken = eq;
            end
            `BR_BNE: begin
                taken = !eq;
            end
            `BR_BLT: begin
                taken = lt_s;
            end
            `BR_BGE: begin
                taken = !lt_s;
            end
            `BR_BLTU: begin
                taken = lt_u;
            end
            `BR_BGEU: begin
                taken = !lt_u;
            end
            // Unconditional for jumps, ecall and mret
            `BR_JUMP: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

endmodule

/* source/alu.sv */
`include "rv_ex_consts.svh"

module alu (
    input  logic [3:0]          alu_op,
    input  logic [`RV_XLEN-1:0] in1,
    input  logic [`RV_XLEN-1:0] in2,
    output logic [`RV_XLEN-1:0] result
);

    logic [4:0]          shamt;
    logic [`RV_XLEN-1:0] sum;

    assign shamt = in2[4:0];
    assign sum   = in1 + in2;

    always_comb begin
        case (alu_op)
            `ALU_ADD: begin
                result = sum;
            end
            `ALU_SUB: begin
                result = in1 - in2;
            end
            `ALU_SLL: begin
                result = in1 << shamt;
            end
            `ALU_SLT: begin
                result = {{(`RV_XLEN-1){1'b0}}, $signed(in1) < $signed(in2)};
            end
            `ALU_SLTU: begin
                result = {{(`RV_XLEN-1){1'b0}}, in1 < in2};
            end
            `ALU_XOR: begin
                result = in1 ^ in2;
            end
            `ALU_SRL: begin
                result = in1 >> shamt;
            end
            `ALU_SRA: begin
                result = $signed(in1) >>> shamt;
            end
            `ALU_OR: begin
                result = in1 | in2;
            end
            `ALU_AND: begin
                result = in1 & in2;
            end
            // LUI and CSRRW(I)
            `ALU_CP_IN2: begin
                result = in2;
            end
            // Jump target is always halfword aligned
            `ALU_JALR: begin
                result = {sum[`RV_XLEN-1:1], 1'b0};
            end
            `ALU_CSRRC: begin
                result = in1 & ~in2;
            end
            default: begin
                result = sum;
            end
        endcase
    end

endmodule

/* source/ex_ctrl.sv */
`include "rv_ex_consts.svh"

module ex_ctrl import rv_ex_pkg::*; (
    input  logic                clk,
    input  logic                in_valid,
    input  logic [6:0]          opcode,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    input  logic [`RV_XLEN-1:0] data1,
    input  logic [`RV_XLEN-1:0] data2,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [`RV_XLEN-1:0] z_,
    output logic [`RV_XLEN-1:0] in1,
    output logic [`RV_XLEN-1:0] in2,
    output logic [2:0]          branch_alu_op,
    output logic [3:0]          alu_op,
    output wb_sel_e             wb_sel
);

    logic is_system_call;
    logic is_csr;

    // ecall and mret share funct3 000
    assign is_system_call = (opcode == `RV_OP_SYSTEM) && (funct3 == 3'b000);
    assign is_csr         = (opcode == `RV_OP_SYSTEM) && (funct3 != 3'b000);

    // ALU operand select
    always_comb begin
        case (opcode)
            `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_BRANCH: begin
                in1 = pc;
                in2 = imm;
            end
            `RV_OP_JALR, `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_IMM: begin
                in1 = data1;
                in2 = imm;
            end
            `RV_OP_REG: begin
                in1 = data1;
                in2 = data2;
            end
            `RV_OP_SYSTEM: begin
                // Old CSR value always on in1
                in1 = z_;
                if (funct3 == 3'b000 || funct3[2]) begin
                    in2 = imm;
                end else begin
                    in2 = data1;
                end
            end
            default: begin
                in1 = '0;
                in2 = '0;
            end
        endcase
    end

    // Branch op
    always_comb begin
        if (opcode == `RV_OP_JAL || opcode == `RV_OP_JALR || is_system_call) begin
            branch_alu_op = `BR_JUMP;
        end else if (opcode == `RV_OP_BRANCH) begin
            branch_alu_op = funct3;
        end else begin
            branch_alu_op = `BR_NO_JUMP;
        end
    end

    // ALU op
    always_comb begin
        if (opcode == `RV_OP_LUI) begin
            alu_op = `ALU_CP_IN2;
        end else if (opcode == `RV_OP_JALR) begin
            alu_op = `ALU_JALR;
        end else if (opcode == `RV_OP_REG || opcode == `RV_OP_IMM) begin
            // funct7[5] picks SUB for REG only, and SRA/SRAI for both
            if ((opcode == `RV_OP_REG && funct3 == 3'b000) || funct3 == 3'b101) begin
                alu_op = {funct7[5], funct3};
            end else begin
                alu_op = {1'b0, funct3};
            end
        end else if (is_csr) begin
            case (funct3[1:0])
                2'b01:   alu_op = `ALU_CP_IN2;
                2'b10:   alu_op = `ALU_OR;
                2'b11:   alu_op = `ALU_CSRRC;
                default: alu_op = `ALU_ADD;
            endcase
        end else begin
            // AUIPC, JAL, branches, loads, stores, ecall and mret
            alu_op = `ALU_ADD;
        end
    end

    // Write-back source
    always_comb begin
        if (opcode == `RV_OP_JAL || opcode == `RV_OP_JALR) begin
            wb_sel = WB_LINK;
        end else if (is_csr) begin
            wb_sel = WB_CSR;
        end else begin
            wb_sel = WB_ALU;
        end
    end

    // Decode must only hand over known opcodes
    known_opcode_a: assert property (@(posedge clk) in_valid |-> opcode inside {
        `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_JALR, `RV_OP_BRANCH,
        `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_IMM, `RV_OP_REG, `RV_OP_SYSTEM});

endmodule

/* source/imm_gen.sv */
`include "rv_ex_consts.svh"

module imm_gen import rv_ex_pkg::*; (
    input  inst_word_u          inst,
    output logic [`RV_XLEN-1:0] imm
);

    always_comb begin
        case (inst.r.opcode)
            `RV_OP_JALR, `RV_OP_LOAD, `RV_OP_IMM: begin
                imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            end
            `RV_OP_STORE: begin
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            end
            // B immediate is scattered over the S fields
            `RV_OP_BRANCH: begin
                imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_lo[0],
                       inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
            end
            `RV_OP_LUI, `RV_OP_AUIPC: begin
                imm = {inst.u.imm, 12'b0};
            end
            // J immediate is scattered over the U field
            `RV_OP_JAL: begin
                imm = {{12{inst.u.imm[19]}}, inst.u.imm[7:0], inst.u.imm[8],
                       inst.u.imm[18:9], 1'b0};
            end
            `RV_OP_SYSTEM: begin
                // zimm sits in the rs1 slot
                if (inst.i.funct3[2]) begin
                    imm = {27'b0, inst.i.rs1};
                end else begin
                    imm = '0;
                end
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* source/rv_ex_pkg.sv */
`include "rv_ex_consts.svh"

package rv_ex_pkg;

    // R format view
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // I format view, also JALR, loads and SYSTEM
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // S format view, B immediates share this split
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // U format view, J immediates share this split
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_word_u;

    // Source of the register write-back value
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LINK = 2'd1,
        WB_CSR  = 2'd2
    } wb_sel_e;

    // From decode
    typedef struct packed {
        inst_word_u               inst;
        logic [`RV_XLEN-1:0]      pc;
        logic [`RV_XLEN-1:0]      rs1_data;
        logic [`RV_XLEN-1:0]      rs2_data;
        logic [`RV_XLEN-1:0]      csr_rdata;
    } ex_in_t;

    // Toward the memory stage
    typedef struct packed {
        logic [4:0]               rd;
        logic [`RV_XLEN-1:0]      rd_wdata;
        logic [`RV_XLEN-1:0]      alu_result;
        logic [`RV_XLEN-1:0]      csr_wdata;
        logic                     redirect;
        logic [`RV_XLEN-1:0]      redirect_pc;
    } ex_out_t;

endpackage

/* source/rv_ex_consts.svh */
`ifndef RV_EX_CONSTS_SVH
`define RV_EX_CONSTS_SVH

// Data path width
`define RV_XLEN 32

// Major opcodes
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011
`define RV_OP_SYSTEM  7'b1110011

// ALU ops, low bits follow funct3 and top bit is funct7[5]
`define ALU_ADD     4'b0000
`define ALU_SUB     4'b1000
`define ALU_SLL     4'b0001
`define ALU_SLT     4'b0010
`define ALU_SLTU    4'b0011
`define ALU_XOR     4'b0100
`define ALU_SRL     4'b0101
`define ALU_SRA     4'b1101
`define ALU_OR      4'b0110
`define ALU_AND     4'b0111
`define ALU_CP_IN2  4'b1001
`define ALU_JALR    4'b1010
`define ALU_CSRRC   4'b1011

// Branch ops, 010 and 011 are unused by funct3
`define BR_BEQ      3'b000
`define BR_BNE      3'b001
`define BR_JUMP     3'b010
`define BR_NO_JUMP  3'b011
`define BR_BLT      3'b100
`define BR_BGE      3'b101
`define BR_BLTU     3'b110
`define BR_BGEU     3'b111

`endif
